// File: Makefile
VERILATOR  ?= verilator
TOP        := targetMuxTb
FILELIST   := filelist.f
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0
BUILD_DIR  := obj_dir
LOG        := sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "Result: PASSED" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: design/addrRequestMux.sv
`default_nettype none

module addrRequestMux
(
	input  wire  sysClk,
	input  wire  sysReset,

	// slot arbiter
	input  wire                                                    i_reqValid,
	input  wire  targetMuxPkg::masterIdxT                          i_reqMaster,
	input  wire  targetMuxPkg::slaveIdxT [targetMuxPkg::NumMasters-1:0] i_targetSlave,

	// master address channels
	input  wire  targetMuxPkg::axiIdT [targetMuxPkg::NumMasters-1:0]    i_masterId,
	input  wire  targetMuxPkg::addrT  [targetMuxPkg::NumMasters-1:0]    i_masterAddr,
	input  wire  targetMuxPkg::lenT   [targetMuxPkg::NumMasters-1:0]    i_masterLen,
	input  wire  targetMuxPkg::sizeT  [targetMuxPkg::NumMasters-1:0]    i_masterSize,
	input  wire  targetMuxPkg::burstT [targetMuxPkg::NumMasters-1:0]    i_masterBurst,

	// selected target and registered address bus
	output var   targetMuxPkg::slaveIdxT o_target,
	output var   targetMuxPkg::tagIdT    o_tagId,
	output var   targetMuxPkg::addrT     o_addr,
	output var   targetMuxPkg::lenT      o_len,
	output var   targetMuxPkg::sizeT     o_size,
	output var   targetMuxPkg::burstT    o_burst
);

	import targetMuxPkg::*;

	// ======================================================================
	// select the granted master
	// ======================================================================

	axiIdT selId;
	addrT  selAddr;
	lenT   selLen;
	sizeT  selSize;
	burstT selBurst;
	tagIdT selTagId;

	assign selId    = i_masterId[i_reqMaster];
	assign selAddr  = i_masterAddr[i_reqMaster];
	assign selLen   = i_masterLen[i_reqMaster];
	assign selSize  = i_masterSize[i_reqMaster];
	assign selBurst = i_masterBurst[i_reqMaster];

	// master index goes above the ID so responses can be routed back
	assign selTagId = {i_reqMaster, selId};

	// target is needed in the same cycle for the valid decode
	assign o_target = i_targetSlave[i_reqMaster];

	// ======================================================================
	// address bus register
	// ======================================================================

	// reloads every cycle the request stays up, holds otherwise
	always_ff @(posedge sysClk or negedge sysReset)
	begin
		if (!sysReset)
		begin
			o_tagId <= '0;
			o_addr  <= '0;
			o_len   <= '0;
			o_size  <= '0;
			o_burst <= '0;
		end
		else if (i_reqValid)
		begin
			o_tagId <= selTagId;
			o_addr  <= selAddr;
			o_len   <= selLen;
			o_size  <= selSize;
			o_burst <= selBurst;
		end
	end

endmodule

`default_nettype wire

// File: design/addrTargetMux.sv
`default_nettype none

module addrTargetMux
(
	input  wire  sysClk,
	input  wire  sysReset,

	// ======================================================================
	// slot arbiter
	// ======================================================================
	input  wire                                                    i_reqValid,
	input  wire  targetMuxPkg::masterIdxT                          i_reqMaster,
	input  wire  targetMuxPkg::slaveIdxT [targetMuxPkg::NumMasters-1:0] i_targetSlave,
	output wire                                                    o_arbEnable,

	// ======================================================================
	// master ports
	// ======================================================================
	input  wire  targetMuxPkg::axiIdT [targetMuxPkg::NumMasters-1:0]    i_masterId,
	input  wire  targetMuxPkg::addrT  [targetMuxPkg::NumMasters-1:0]    i_masterAddr,
	input  wire  targetMuxPkg::lenT   [targetMuxPkg::NumMasters-1:0]    i_masterLen,
	input  wire  targetMuxPkg::sizeT  [targetMuxPkg::NumMasters-1:0]    i_masterSize,
	input  wire  targetMuxPkg::burstT [targetMuxPkg::NumMasters-1:0]    i_masterBurst,
	output wire  [targetMuxPkg::NumMasters-1:0]                        o_masterAReady,

	// ======================================================================
	// slave ports
	// ======================================================================
	output wire  [targetMuxPkg::NumSlaves-1:0]                         o_slaveAValid,
	input  wire  [targetMuxPkg::NumSlaves-1:0]                         i_slaveAReady,
	output wire  targetMuxPkg::tagIdT [targetMuxPkg::NumSlaves-1:0]     o_slaveId,
	output wire  targetMuxPkg::lenT   [targetMuxPkg::NumSlaves-1:0]     o_slaveLen,
	output wire  targetMuxPkg::addrT  [targetMuxPkg::DecErrSlave-1:0]   o_slaveAddr,
	output wire  targetMuxPkg::sizeT  [targetMuxPkg::DecErrSlave-1:0]   o_slaveSize,
	output wire  targetMuxPkg::burstT [targetMuxPkg::DecErrSlave-1:0]   o_slaveBurst,

	// ======================================================================
	// write data controller
	// ======================================================================
	output wire                                                    o_dataFifoWr,
	output wire  targetMuxPkg::tagIdT                              o_srcPort,
	output wire  targetMuxPkg::slaveIdxT                           o_destPort
);

	import targetMuxPkg::*;

	// shared address bus between the stages
	slaveIdxT target;    // combinational, follows the arbiter
	tagIdT    tagId;
	addrT     addr;
	lenT      len;
	sizeT     size;
	burstT    burst;

	logic     accept;

	addrRequestMux addrRequestMux_i
	(
		.sysClk        (sysClk),
		.sysReset      (sysReset),
		.i_reqValid    (i_reqValid),
		.i_reqMaster   (i_reqMaster),
		.i_targetSlave (i_targetSlave),
		.i_masterId    (i_masterId),
		.i_masterAddr  (i_masterAddr),
		.i_masterLen   (i_masterLen),
		.i_masterSize  (i_masterSize),
		.i_masterBurst (i_masterBurst),
		.o_target      (target),
		.o_tagId       (tagId),
		.o_addr        (addr),
		.o_len         (len),
		.o_size        (size),
		.o_burst       (burst)
	);

	slaveValidCtrl slaveValidCtrl_i
	(
		.sysClk         (sysClk),
		.sysReset       (sysReset),
		.i_reqValid     (i_reqValid),
		.i_reqMaster    (i_reqMaster),
		.i_target       (target),
		.i_slaveAReady  (i_slaveAReady),
		.o_slaveAValid  (o_slaveAValid),
		.o_masterAReady (o_masterAReady),
		.o_accept       (accept)
	);

	slavePortDriver slavePortDriver_i
	(
		.sysClk       (sysClk),
		.sysReset     (sysReset),
		.i_accept     (accept),
		.i_target     (target),
		.i_tagId      (tagId),
		.i_addr       (addr),
		.i_len        (len),
		.i_size       (size),
		.i_burst      (burst),
		.o_slaveId    (o_slaveId),
		.o_slaveLen   (o_slaveLen),
		.o_slaveAddr  (o_slaveAddr),
		.o_slaveSize  (o_slaveSize),
		.o_slaveBurst (o_slaveBurst),
		.o_dataFifoWr (o_dataFifoWr),
		.o_srcPort    (o_srcPort),
		.o_destPort   (o_destPort)
	);

	// arbiter may move on once the slave has taken the address
	assign o_arbEnable = accept;

endmodule

`default_nettype wire

// File: design/slavePortDriver.sv
`default_nettype none

module slavePortDriver
(
	input  wire  sysClk,
	input  wire  sysReset,

	input  wire                             i_accept,
	input  wire  targetMuxPkg::slaveIdxT    i_target,

	// registered address bus
	input  wire  targetMuxPkg::tagIdT       i_tagId,
	input  wire  targetMuxPkg::addrT        i_addr,
	input  wire  targetMuxPkg::lenT         i_len,
	input  wire  targetMuxPkg::sizeT        i_size,
	input  wire  targetMuxPkg::burstT       i_burst,

	// every slave, the decode-error slave included
	output var   targetMuxPkg::tagIdT [targetMuxPkg::NumSlaves-1:0]   o_slaveId,
	output var   targetMuxPkg::lenT   [targetMuxPkg::NumSlaves-1:0]   o_slaveLen,

	// mapped slaves only
	output var   targetMuxPkg::addrT  [targetMuxPkg::DecErrSlave-1:0] o_slaveAddr,
	output var   targetMuxPkg::sizeT  [targetMuxPkg::DecErrSlave-1:0] o_slaveSize,
	output var   targetMuxPkg::burstT [targetMuxPkg::DecErrSlave-1:0] o_slaveBurst,

	// write data controller
	output logic                            o_dataFifoWr,
	output var   targetMuxPkg::tagIdT       o_srcPort,
	output var   targetMuxPkg::slaveIdxT    o_destPort
);

	import targetMuxPkg::*;

	// ======================================================================
	// slave port fan-out
	// ======================================================================

	genvar s;
	for (s = 0; s < NumSlaves; s++)
	begin : allPorts
		assign o_slaveId[s]  = i_tagId;
		assign o_slaveLen[s] = i_len;    // decerr slave needs it to count beats
	end

	// decode-error slave never sees address, size or burst
	for (s = 0; s < DecErrSlave; s++)
	begin : mappedPorts
		assign o_slaveAddr[s]  = i_addr;
		assign o_slaveSize[s]  = i_size;
		assign o_slaveBurst[s] = i_burst;
	end

	// ======================================================================
	// route record to data controller
	// ======================================================================

	always_ff @(posedge sysClk or negedge sysReset)
	begin
		if (!sysReset)
		begin
			o_dataFifoWr <= 1'b0;
		end
		else
		begin
			o_dataFifoWr <= i_accept;    // one push per accepted address
		end
	end

	// record of the accepted request
	always_ff @(posedge sysClk)
	begin
		if (i_accept)
		begin
			o_srcPort  <= i_tagId;
			o_destPort <= i_target;
		end
	end

	// valid drops after accept, so accepts never come back to back
	wrSingle: assert property (@(posedge sysClk) disable iff (!sysReset)
		o_dataFifoWr |=> !o_dataFifoWr)
		else $error("data FIFO write held for two cycles");

endmodule

`default_nettype wire

// File: design/slaveValidCtrl.sv
`default_nettype none

module slaveValidCtrl
(
	input  wire  sysClk,
	input  wire  sysReset,

	input  wire                                  i_reqValid,
	input  wire  targetMuxPkg::masterIdxT        i_reqMaster,
	input  wire  targetMuxPkg::slaveIdxT         i_target,

	// slave handshake
	input  wire  [targetMuxPkg::NumSlaves-1:0]   i_slaveAReady,
	output logic [targetMuxPkg::NumSlaves-1:0]   o_slaveAValid,

	// back toward masters and arbiter
	output logic [targetMuxPkg::NumMasters-1:0]  o_masterAReady,
	output logic                                 o_accept
);

	import targetMuxPkg::*;

	logic [NumSlaves-1:0] slaveAValid;
	logic                 accept;

	// only the addressed slave has valid up, so any match is ours
	assign accept = |(slaveAValid & i_slaveAReady);

	// ======================================================================
	// slave valid register
	// ======================================================================

	always_ff @(posedge sysClk or negedge sysReset)
	begin
		if (!sysReset)
		begin
			slaveAValid <= '0;
		end
		else
		begin
			slaveAValid <= '0;    // drops after every accept
			if (i_reqValid && !accept)
			begin
				slaveAValid[i_target] <= 1'b1;
			end
		end
	end

	// ready pulse to the winner, same cycle as the slave accepts
	always_comb
	begin
		o_masterAReady = '0;
		if (i_reqValid && accept)
		begin
			o_masterAReady[i_reqMaster] = 1'b1;
		end
	end

	assign o_slaveAValid = slaveAValid;
	assign o_accept      = accept;    // also frees the arbiter

	// ======================================================================
	// checks
	// ======================================================================

	// at most one valid, and only at the slave the arbiter still points to
	validOneHot: assert property (@(posedge sysClk) disable iff (!sysReset)
		slaveAValid == '0 || slaveAValid == (NumSlaves'(1) << i_target))
		else $error("slave valid not one-hot at the target: %b", slaveAValid);

	// relies on the arbiter keeping the request steady until enable
	genvar s;
	for (s = 0; s < NumSlaves; s++)
	begin : holdChk
		validHold: assert property (@(posedge sysClk) disable iff (!sysReset)
			slaveAValid[s] && !i_slaveAReady[s] |=> slaveAValid[s])
			else $error("valid of slave %0d dropped before ready", s);
	end

endmodule

`default_nettype wire

// File: design/targetMuxPkg.sv
`default_nettype none

package targetMuxPkg;

	// ======================================================================
	// interconnect sizes
	// ======================================================================

	localparam int NumMasters     = 4;
	localparam int MasterIdxWidth = 2;     // encodes one of NumMasters

	localparam int NumSlaves      = 4;     // last one is the decode-error slave
	localparam int SlaveIdxWidth  = 2;

	localparam int IdWidth        = 1;     // transaction ID as seen at a master
	localparam int TagIdWidth     = MasterIdxWidth + IdWidth;

	// address channel fields that are carried through
	localparam int AddrWidth      = 32;
	localparam int LenWidth       = 8;
	localparam int SizeWidth      = 3;
	localparam int BurstWidth     = 2;

	// slave index that answers unmapped addresses
	localparam int DecErrSlave    = NumSlaves - 1;

	// ======================================================================
	// field types
	// ======================================================================

	typedef logic [MasterIdxWidth-1:0] masterIdxT;
	typedef logic [SlaveIdxWidth-1:0]  slaveIdxT;

	typedef logic [IdWidth-1:0]        axiIdT;
	typedef logic [TagIdWidth-1:0]     tagIdT;    // {master index, master ID}

	typedef logic [AddrWidth-1:0]      addrT;
	typedef logic [LenWidth-1:0]       lenT;      // beats minus one
	typedef logic [SizeWidth-1:0]      sizeT;     // bytes per beat, log2
	typedef logic [BurstWidth-1:0]     burstT;    // FIXED, INCR or WRAP

endpackage

`default_nettype wire

// File: filelist.f
design/targetMuxPkg.sv
design/addrRequestMux.sv
design/slaveValidCtrl.sv
design/slavePortDriver.sv
design/addrTargetMux.sv
testbench/targetMuxTb.sv

// File: testbench/targetMuxTb.sv
`default_nettype none

module targetMuxTb;

	import targetMuxPkg::*;

	localparam int ClkPeriod   = 4;
	localparam int ResetCycles = 16;
	localparam int NumRandom   = 40;
	localparam int NumDecErr   = 8;
	localparam int NumOverlap  = 16;
	localparam int NumRequests = NumRandom + NumDecErr + NumOverlap;
	localparam int AcceptLimit = 8;    // cycles from slave ready to arbiter enable

	logic sysClk;
	logic sysReset;

	// arbiter and master side
	logic                      reqValid;
	masterIdxT                 reqMaster;
	slaveIdxT [NumMasters-1:0] targetSlave;
	axiIdT    [NumMasters-1:0] masterId;
	addrT     [NumMasters-1:0] masterAddr;
	lenT      [NumMasters-1:0] masterLen;
	sizeT     [NumMasters-1:0] masterSize;
	burstT    [NumMasters-1:0] masterBurst;
	logic                      arbEnable;
	logic     [NumMasters-1:0] masterAReady;

	// slave and data controller side
	logic     [NumSlaves-1:0]   slaveAValid;
	logic     [NumSlaves-1:0]   slaveAReady;
	tagIdT    [NumSlaves-1:0]   slaveId;
	lenT      [NumSlaves-1:0]   slaveLen;
	addrT     [DecErrSlave-1:0] slaveAddr;
	sizeT     [DecErrSlave-1:0] slaveSize;
	burstT    [DecErrSlave-1:0] slaveBurst;
	logic                       dataFifoWr;
	tagIdT                      srcPort;
	slaveIdxT                   destPort;

	// model of the request on the bus
	masterIdxT expMaster;
	slaveIdxT  expTarget;
	tagIdT     expTag;
	addrT      expAddr;
	lenT       expLen;
	sizeT      expSize;
	burstT     expBurst;
	tagIdT     recTag;       // last accepted request
	slaveIdxT  recTarget;

	logic busLive;      // valid and address bus expected up
	logic holdReq;      // target ready held low
	logic acceptCyc;    // target ready high, accept expected

	logic [31:0] lfsrState;
	int          errCount;
	int          testsRun;
	int          testsFailed;
	int          testErrStart;

	addrTargetMux addrTargetMux_i
	(
		.sysClk         (sysClk),
		.sysReset       (sysReset),
		.i_reqValid     (reqValid),
		.i_reqMaster    (reqMaster),
		.i_targetSlave  (targetSlave),
		.o_arbEnable    (arbEnable),
		.i_masterId     (masterId),
		.i_masterAddr   (masterAddr),
		.i_masterLen    (masterLen),
		.i_masterSize   (masterSize),
		.i_masterBurst  (masterBurst),
		.o_masterAReady (masterAReady),
		.o_slaveAValid  (slaveAValid),
		.i_slaveAReady  (slaveAReady),
		.o_slaveId      (slaveId),
		.o_slaveLen     (slaveLen),
		.o_slaveAddr    (slaveAddr),
		.o_slaveSize    (slaveSize),
		.o_slaveBurst   (slaveBurst),
		.o_dataFifoWr   (dataFifoWr),
		.o_srcPort      (srcPort),
		.o_destPort     (destPort)
	);

	always #(ClkPeriod/2) sysClk = ~sysClk;

	// ======================================================================
	// helpers
	// ======================================================================

	// galois form of x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	function automatic logic [31:0] randBits(input int n);
		logic [31:0] val;
		int          i;
		val = '0;
		for (i = 0; i < n; i++)
		begin
			lfsrState = lfsrNext(lfsrState);
			val       = {val[30:0], lfsrState[0]};    // one step per bit
		end
		return val;
	endfunction

	function automatic logic [NumSlaves-1:0] slaveBit(input slaveIdxT s);
		logic [NumSlaves-1:0] b;
		b    = '0;
		b[s] = 1'b1;
		return b;
	endfunction

	function automatic logic [NumMasters-1:0] masterBit(input masterIdxT m);
		logic [NumMasters-1:0] b;
		b    = '0;
		b[m] = 1'b1;
		return b;
	endfunction

	task automatic reportMismatch(input string name, input string expVal, input string gotVal);
		errCount++;
		$display("ERR %0t %s expected %s got %s", $time, name, expVal, gotVal);
	endtask

	// ======================================================================
	// checks
	// ======================================================================

	// every edge that follows a reset edge, the first one after release included
	resetState: assert property (@(posedge sysClk)
		!$past(sysReset) |->
			slaveAValid == '0 && masterAReady == '0 && !arbEnable && !dataFifoWr)
		else reportMismatch("o_slaveAValid/o_masterAReady/o_arbEnable/o_dataFifoWr", "0",
			$sformatf("%h", $sampled({slaveAValid, masterAReady, arbEnable, dataFifoWr})));

	validRoute: assert property (@(posedge sysClk) disable iff (!sysReset)
		busLive |-> slaveAValid == slaveBit(expTarget))
		else reportMismatch("o_slaveAValid", $sformatf("%b", slaveBit($sampled(expTarget))),
			$sformatf("%b", $sampled(slaveAValid)));

	idRoute: assert property (@(posedge sysClk) disable iff (!sysReset)
		busLive |-> slaveId == {NumSlaves{expTag}})
		else reportMismatch("o_slaveId", $sformatf("%h", {NumSlaves{$sampled(expTag)}}),
			$sformatf("%h", $sampled(slaveId)));

	lenRoute: assert property (@(posedge sysClk) disable iff (!sysReset)
		busLive |-> slaveLen == {NumSlaves{expLen}})
		else reportMismatch("o_slaveLen", $sformatf("%h", {NumSlaves{$sampled(expLen)}}),
			$sformatf("%h", $sampled(slaveLen)));

	addrRoute: assert property (@(posedge sysClk) disable iff (!sysReset)
		busLive |-> slaveAddr == {DecErrSlave{expAddr}})
		else reportMismatch("o_slaveAddr", $sformatf("%h", {DecErrSlave{$sampled(expAddr)}}),
			$sformatf("%h", $sampled(slaveAddr)));

	// size and burst share one check, shown as {size, burst} per port
	sizeBurstRoute: assert property (@(posedge sysClk) disable iff (!sysReset)
		busLive |-> slaveSize == {DecErrSlave{expSize}} && slaveBurst == {DecErrSlave{expBurst}})
		else reportMismatch("o_slaveSize/o_slaveBurst",
			$sformatf("%h/%h", $sampled(expSize), $sampled(expBurst)),
			$sformatf("%h/%h", $sampled(slaveSize), $sampled(slaveBurst)));

	// back-pressure, other slaves' readies are random here
	holdGrant: assert property (@(posedge sysClk) disable iff (!sysReset)
		holdReq |-> masterAReady == '0 && !arbEnable)
		else reportMismatch("o_arbEnable/o_masterAReady", "0/0",
			$sformatf("%b/%b", $sampled(arbEnable), $sampled(masterAReady)));

	holdValid: assert property (@(posedge sysClk) disable iff (!sysReset)
		holdReq |=> slaveAValid == slaveBit(expTarget))
		else reportMismatch("o_slaveAValid", $sformatf("%b", slaveBit($sampled(expTarget))),
			$sformatf("%b", $sampled(slaveAValid)));

	acceptGrant: assert property (@(posedge sysClk) disable iff (!sysReset)
		acceptCyc |-> arbEnable && masterAReady == masterBit(expMaster))
		else reportMismatch("o_arbEnable/o_masterAReady",
			$sformatf("1/%b", masterBit($sampled(expMaster))),
			$sformatf("%b/%b", $sampled(arbEnable), $sampled(masterAReady)));

	acceptDrop: assert property (@(posedge sysClk) disable iff (!sysReset)
		acceptCyc |=> slaveAValid == '0)
		else reportMismatch("o_slaveAValid", "0", $sformatf("%b", $sampled(slaveAValid)));

	recordWrite: assert property (@(posedge sysClk) disable iff (!sysReset)
		acceptCyc |=> dataFifoWr && srcPort == recTag && destPort == recTarget)
		else reportMismatch("o_dataFifoWr/o_srcPort/o_destPort",
			$sformatf("1/%h/%h", $sampled(recTag), $sampled(recTarget)),
			$sformatf("%b/%h/%h", $sampled(dataFifoWr), $sampled(srcPort), $sampled(destPort)));

	recordSingle: assert property (@(posedge sysClk) disable iff (!sysReset)
		dataFifoWr |-> $past(acceptCyc))
		else reportMismatch("o_dataFifoWr", "0", "1");

	decErrPort: assert property (@(posedge sysClk) disable iff (!sysReset)
		busLive && expTarget == slaveIdxT'(DecErrSlave) |-> slaveAValid[DecErrSlave]
			&& slaveId[DecErrSlave] == expTag && slaveLen[DecErrSlave] == expLen)
		else reportMismatch("decode-error o_slaveAValid/o_slaveId/o_slaveLen",
			$sformatf("1/%h/%h", $sampled(expTag), $sampled(expLen)),
			$sformatf("%b/%h/%h", $sampled(slaveAValid[DecErrSlave]),
				$sampled(slaveId[DecErrSlave]), $sampled(slaveLen[DecErrSlave])));

	// ======================================================================
	// stimulus
	// ======================================================================

	// one request, from grant to the falling edge after acceptance
	task automatic runRequest(input logic toDecErr);
		int delay;
		int waited;
		int m;
		for (m = 0; m < NumMasters; m++)
		begin
			targetSlave[m] = slaveIdxT'(randBits(SlaveIdxWidth));
			masterId[m]    = axiIdT'(randBits(IdWidth));
			masterAddr[m]  = randBits(AddrWidth);
			masterLen[m]   = lenT'(randBits(LenWidth));
			masterSize[m]  = sizeT'(randBits(SizeWidth));
			masterBurst[m] = burstT'(randBits(BurstWidth));
		end
		reqMaster = masterIdxT'(randBits(MasterIdxWidth));
		if (toDecErr)
		begin
			targetSlave[reqMaster] = slaveIdxT'(DecErrSlave);
		end
		expMaster   = reqMaster;
		expTarget   = targetSlave[reqMaster];
		expTag      = {reqMaster, masterId[reqMaster]};    // master index above the ID
		expAddr     = masterAddr[reqMaster];
		expLen      = masterLen[reqMaster];
		expSize     = masterSize[reqMaster];
		expBurst    = masterBurst[reqMaster];
		reqValid    = 1'b1;
		slaveAReady = NumSlaves'(randBits(NumSlaves)) & ~slaveBit(expTarget);
		delay       = int'(randBits(2));
		@(negedge sysClk);
		busLive = 1'b1;
		repeat (delay)
		begin
			holdReq     = 1'b1;
			slaveAReady = NumSlaves'(randBits(NumSlaves)) & ~slaveBit(expTarget);
			@(negedge sysClk);
		end
		holdReq     = 1'b0;
		acceptCyc   = 1'b1;
		slaveAReady = NumSlaves'(randBits(NumSlaves)) | slaveBit(expTarget);
		waited      = 0;
		#1;    // mid cycle, enable is settled
		while (!arbEnable && waited < AcceptLimit)
		begin
			@(negedge sysClk);
			#1;
			waited++;
		end
		if (!arbEnable)
		begin
			errCount++;
			$display("slave %0d never accepted the request from master %0d, time %0t",
				expTarget, expMaster, $time);
		end
		@(negedge sysClk);
		recTag      = expTag;
		recTarget   = expTarget;
		acceptCyc   = 1'b0;
		busLive     = 1'b0;
		reqValid    = 1'b0;
		slaveAReady = '0;
	endtask

	task automatic finishTest(input string name);
		repeat (2) @(negedge sysClk);    // let the route record checks run
		testsRun++;
		if (errCount != testErrStart)
		begin
			testsFailed++;
			$display("test %-24s failed, %0d errors", name, errCount - testErrStart);
		end
		else
		begin
			$display("test %-24s ok", name);
		end
		testErrStart = errCount;
	endtask

	initial
	begin
		int i;
		lfsrState    = 32'd68548;
		errCount     = 0;
		testsRun     = 0;
		testsFailed  = 0;
		testErrStart = 0;
		sysClk       = 1'b0;
		sysReset     = 1'b0;
		reqValid     = 1'b0;
		reqMaster    = '0;
		targetSlave  = '0;
		masterId     = '0;
		masterAddr   = '0;
		masterLen    = '0;
		masterSize   = '0;
		masterBurst  = '0;
		slaveAReady  = '0;
		busLive      = 1'b0;
		holdReq      = 1'b0;
		acceptCyc    = 1'b0;
		repeat (ResetCycles) @(negedge sysClk);
		sysReset = 1'b1;
		finishTest("reset state");

		for (i = 0; i < NumRandom; i++)
		begin
			runRequest(1'b0);
			repeat (int'(randBits(1))) @(negedge sysClk);
		end
		finishTest("routing and back-pressure");

		for (i = 0; i < NumDecErr; i++)
		begin
			runRequest(1'b1);
		end
		finishTest("decode-error slave");

		// next grant lands while the route record is still pending
		for (i = 0; i < NumOverlap; i++)
		begin
			runRequest(1'b0);
		end
		finishTest("back-to-back requests");

		$display("tests %0d, failed %0d, errors %0d", testsRun, testsFailed, errCount);
		if (errCount == 0)
		begin
			$display("Result: PASSED");
		end
		else
		begin
			$display("Result: FAILED");
		end
		$finish;
	end

	// watchdog
	initial
	begin
		#((ResetCycles + NumRequests * 8) * ClkPeriod);
		$display("run did not finish within %0d requests worth of cycles", NumRequests);
		$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire
